/* sources.f */
+incdir+.
axi_csr_pkg.sv
axi_sub_frontend.sv
csr_cpuif_bridge.sv
periph_csr_block.sv
axi_csr_top.sv
tb_axi_csr_top.sv

/* tb_axi_csr_tasks.svh */
// AXI drivers, compare tasks and directed tests for the CSR subordinate testbench
`ifndef TB_AXI_CSR_TASKS_SVH
`define TB_AXI_CSR_TASKS_SVH

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %s resp: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %s id: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_user(input string name, input axi_user_t exp, input axi_user_t act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %s user: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Ready sampled mid-cycle and taken on the next rising edge
  task automatic ar_send(input axi_addr_t addr, input axi_id_t id, input axi_user_t user,
                         input logic [7:0] len);
    logic taken;
    int   cnt;
    araddr_i  = addr;
    arid_i    = id;
    aruser_i  = user;
    arlen_i   = len;
    arvalid_i = 1'b1;
    cnt = 0;
    while (arvalid_i) begin
      if (cnt > TIMEOUT) fail_stop("Timeout: read address was never accepted");
      @(negedge clk_i);
      taken = arready_o;
      @(posedge clk_i);
      #1;
      if (taken) arvalid_i = 1'b0;
      cnt++;
    end
  endtask

  task automatic aw_w_send(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input axi_id_t id, input axi_user_t user, input logic [7:0] len);
    logic aw_take;
    logic w_take;
    int   cnt;
    awaddr_i  = addr;
    awid_i    = id;
    awuser_i  = user;
    awlen_i   = len;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wuser_i   = user;
    wvalid_i  = 1'b1;
    cnt = 0;
    while (awvalid_i || wvalid_i) begin
      if (cnt > TIMEOUT) fail_stop("Timeout: write address or data was never accepted");
      @(negedge clk_i);
      aw_take = awvalid_i && awready_o;
      w_take  = wvalid_i && wready_o;
      @(posedge clk_i);
      #1;
      if (aw_take) awvalid_i = 1'b0;
      if (w_take) wvalid_i = 1'b0;
      cnt++;
    end
  endtask

  // Returns after the edge that takes the response when rready is high
  task automatic r_wait(output axi_data_t data, output axi_resp_t resp, output axi_id_t id,
                        output axi_user_t user, output logic last);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!rvalid_o) begin
      cnt++;
      if (cnt > TIMEOUT) fail_stop("Timeout: no read response arrived");
      @(negedge clk_i);
    end
    data = rdata_o;
    resp = rresp_o;
    id   = rid_o;
    user = ruser_o;
    last = rlast_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic b_wait(output axi_resp_t resp, output axi_id_t id, output axi_user_t user);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!bvalid_o) begin
      cnt++;
      if (cnt > TIMEOUT) fail_stop("Timeout: no write response arrived");
      @(negedge clk_i);
    end
    resp = bresp_o;
    id   = bid_o;
    user = buser_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic axi_read(input string name, input axi_addr_t addr, input axi_id_t id,
                          input logic [7:0] len, input axi_resp_t exp_resp,
                          input axi_data_t exp_data);
    axi_user_t user;
    axi_data_t data;
    axi_resp_t resp;
    axi_id_t   rid;
    axi_user_t ruser;
    logic      last;
    user = $urandom();
    ar_send(addr, id, user, len);
    r_wait(data, resp, rid, ruser, last);
    check_resp(name, exp_resp, resp);
    check_data(name, exp_data, data);
    check_id(name, id, rid);
    check_user(name, user, ruser);
    check_flag({name, " rlast"}, 1'b1, last);
  endtask

  task automatic axi_write(input string name, input axi_addr_t addr, input axi_data_t data,
                           input axi_strb_t strb, input axi_id_t id, input logic [7:0] len,
                           input axi_resp_t exp_resp);
    axi_user_t user;
    axi_resp_t resp;
    axi_id_t   bid;
    axi_user_t buser;
    user = $urandom();
    aw_w_send(addr, data, strb, id, user, len);
    b_wait(resp, bid, buser);
    check_resp(name, exp_resp, resp);
    check_id(name, id, bid);
    check_user(name, user, buser);
    if (exp_resp == RESP_OKAY) begin
      model_write(addr, data, strb);
    end
  endtask

  task automatic reset_and_id_test();
    check_flag("reset arready", 1'b1, arready_o);
    check_flag("reset awready", 1'b1, awready_o);
    check_flag("reset wready", 1'b1, wready_o);
    check_flag("reset rvalid", 1'b0, rvalid_o);
    check_flag("reset bvalid", 1'b0, bvalid_o);
    axi_read("id register", 32'h0, 8'h11, 8'd0, RESP_OKAY, {32'h0, CSR_ID_VALUE});
    for (int i = 1; i < NUM_CSRS; i++) begin
      axi_read("scratch after reset", axi_addr_t'(i * 4), 8'h11, 8'd0, RESP_OKAY, '0);
    end
  endtask

  task automatic lane_steering_test();
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    for (int i = 1; i < NUM_CSRS; i++) begin
      addr = axi_addr_t'(i * 4);
      data = {$urandom(), $urandom()};
      strb = addr[2] ? 8'hF0 : 8'h0F;
      axi_write("lane write", addr, data, strb, 8'h22, 8'd0, RESP_OKAY);
    end
    for (int i = 1; i < NUM_CSRS; i++) begin
      addr = axi_addr_t'(i * 4);
      axi_read("lane read", addr, 8'h22, 8'd0, RESP_OKAY, expected_read(addr));
    end
    // Strobes of the unselected lane must have no effect
    repeat (20) begin
      addr = axi_addr_t'((1 + $urandom_range(14)) * 4);
      data = {$urandom(), $urandom()};
      strb = axi_strb_t'($urandom());
      axi_write("partial write", addr, data, strb, 8'h11, 8'd0, RESP_OKAY);
      axi_read("partial read", addr, 8'h11, 8'd0, RESP_OKAY, expected_read(addr));
    end
  endtask

  task automatic error_response_test();
    axi_data_t data;
    data = {$urandom(), $urandom()};
    axi_write("write to id register", 32'h0, data, 8'hFF, 8'h11, 8'd0, RESP_SLVERR);
    axi_read("id register kept", 32'h0, 8'h11, 8'd0, RESP_OKAY, expected_read(32'h0));
    axi_read("unmapped read", 32'h80, 8'h11, 8'd0, RESP_SLVERR, '0);
    axi_write("unmapped write", 32'h80, data, 8'hFF, 8'h11, 8'd0, RESP_SLVERR);
    // Aliases onto register 1 in the low address bits
    axi_write("unmapped alias write", 32'h84, data, 8'hFF, 8'h11, 8'd0, RESP_SLVERR);
    axi_read("after alias write", 32'h4, 8'h11, 8'd0, RESP_OKAY, expected_read(32'h4));
    axi_read("burst read", 32'h8, 8'h11, 8'd1, RESP_SLVERR, '0);
    axi_write("burst write", 32'h8, data, 8'hFF, 8'h11, 8'd1, RESP_SLVERR);
    axi_read("after burst write", 32'h8, 8'h11, 8'd0, RESP_OKAY, expected_read(32'h8));
  endtask

  task automatic id_filter_test();
    axi_data_t data;
    data = {$urandom(), $urandom()};
    disable_id_filtering_i = 1'b0;
    axi_write("unprivileged write", 32'h1C, data, 8'hFF, 8'h5A, 8'd0, RESP_SLVERR);
    axi_read("unprivileged read", 32'h1C, 8'h5A, 8'd0, RESP_SLVERR, '0);
    axi_read("after rejected write", 32'h1C, 8'h33, 8'd0, RESP_OKAY, expected_read(32'h1C));
    axi_write("privileged write", 32'h1C, data, 8'hF0, 8'h44, 8'd0, RESP_OKAY);
    axi_read("privileged read", 32'h1C, 8'h44, 8'd0, RESP_OKAY, expected_read(32'h1C));
    disable_id_filtering_i = 1'b1;
    data = {$urandom(), $urandom()};
    axi_write("filter off write", 32'h20, data, 8'hFF, 8'h5A, 8'd0, RESP_OKAY);
    axi_read("filter off read", 32'h20, 8'h5A, 8'd0, RESP_OKAY, expected_read(32'h20));
    disable_id_filtering_i = 1'b0;
  endtask

  task automatic echo_backpressure_test();
    axi_data_t data0;
    axi_data_t data;
    axi_resp_t resp0;
    axi_id_t   id0;
    axi_user_t user0;
    axi_user_t user;
    logic      last;
    rready_i = 1'b0;
    user0 = $urandom();
    ar_send(32'h24, 8'h33, user0, 8'd0);
    r_wait(data0, resp0, id0, user, last);
    check_resp("held read", RESP_OKAY, resp0);
    check_data("held read", expected_read(32'h24), data0);
    check_id("held read", 8'h33, id0);
    check_user("held read", user0, user);
    check_flag("held read rlast", 1'b1, last);
    // Second read waits behind the held response
    araddr_i  = 32'h28;
    arid_i    = 8'h22;
    arvalid_i = 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check_flag("held rvalid", 1'b1, rvalid_o);
      check_data("held rdata", data0, rdata_o);
      check_resp("held rresp", RESP_OKAY, rresp_o);
      check_id("held rid", id0, rid_o);
      check_user("held ruser", user0, ruser_o);
      check_flag("second ar blocked", 1'b0, arready_o);
      @(posedge clk_i);
      #1;
    end
    rready_i = 1'b1;
    @(posedge clk_i);
    #1;
    axi_read("second read", 32'h28, 8'h22, 8'd0, RESP_OKAY, expected_read(32'h28));

    bready_i = 1'b0;
    data = {$urandom(), $urandom()};
    aw_w_send(32'h30, data, 8'hFF, 8'h44, user0, 8'd0);
    model_write(32'h30, data, 8'hFF);
    b_wait(resp0, id0, user);
    check_resp("held write", RESP_OKAY, resp0);
    check_id("held write", 8'h44, id0);
    check_user("held write", user0, user);
    repeat (6) begin
      @(negedge clk_i);
      check_flag("held bvalid", 1'b1, bvalid_o);
      check_resp("held bresp", RESP_OKAY, bresp_o);
      check_id("held bid", 8'h44, bid_o);
      check_user("held buser", user0, buser_o);
      check_flag("held awready", 1'b0, awready_o);
      @(posedge clk_i);
      #1;
    end
    bready_i = 1'b1;
    @(posedge clk_i);
    #1;
    axi_read("after held write", 32'h30, 8'h11, 8'd0, RESP_OKAY, expected_read(32'h30));
  endtask

`endif

/* tb_axi_csr_top.sv */
// Testbench for the AXI CSR subordinate, with a shadow register model and directed tests
module tb_axi_csr_top
  import axi_csr_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned TIMEOUT = 50;

  logic       clk_i;
  logic       rst_ni;

  axi_addr_t  araddr_i;
  logic [1:0] arburst_i;
  logic [2:0] arsize_i;
  logic [7:0] arlen_i;
  axi_user_t  aruser_i;
  axi_id_t    arid_i;
  logic       arlock_i;
  logic       arvalid_i;
  logic       arready_o;

  axi_data_t  rdata_o;
  axi_resp_t  rresp_o;
  axi_id_t    rid_o;
  axi_user_t  ruser_o;
  logic       rlast_o;
  logic       rvalid_o;
  logic       rready_i;

  axi_addr_t  awaddr_i;
  logic [1:0] awburst_i;
  logic [2:0] awsize_i;
  logic [7:0] awlen_i;
  axi_user_t  awuser_i;
  axi_id_t    awid_i;
  logic       awlock_i;
  logic       awvalid_i;
  logic       awready_o;

  axi_data_t  wdata_i;
  axi_strb_t  wstrb_i;
  axi_user_t  wuser_i;
  logic       wlast_i;
  logic       wvalid_i;
  logic       wready_o;

  axi_resp_t  bresp_o;
  axi_id_t    bid_o;
  axi_user_t  buser_o;
  logic       bvalid_o;
  logic       bready_i;

  logic       disable_id_filtering_i;
  axi_id_t    priv_ids_i [NUM_PRIV_IDS];

  // Shadow copy of the register file with the ID word in entry 0
  csr_data_t  shadow [NUM_CSRS];

  axi_csr_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Read data as the AXI port should return it
  function automatic axi_data_t expected_read(input axi_addr_t addr);
    csr_data_t word;
    if (addr >= 32'h40) begin
      return '0;
    end
    word = shadow[addr[5:2]];
    return addr[2] ? {word, 32'h0} : {32'h0, word};
  endfunction

  // Only the strobed bytes of the selected lane reach the register
  function automatic void model_write(input axi_addr_t addr, input axi_data_t data,
                                      input axi_strb_t strb);
    int lane;
    lane = addr[2] ? 4 : 0;
    for (int b = 0; b < 4; b++) begin
      if (strb[lane + b]) begin
        shadow[addr[5:2]][b*8 +: 8] = data[(lane + b)*8 +: 8];
      end
    end
  endfunction

  `include "tb_axi_csr_tasks.svh"

  initial begin
    void'($urandom(32'h580ab968));
    rst_ni                 = 1'b0;
    araddr_i               = '0;
    arburst_i              = 2'b01;
    arsize_i               = 3'd3;
    arlen_i                = 8'd0;
    aruser_i               = '0;
    arid_i                 = '0;
    arlock_i               = 1'b0;
    arvalid_i              = 1'b0;
    rready_i               = 1'b1;
    awaddr_i               = '0;
    awburst_i              = 2'b01;
    awsize_i               = 3'd3;
    awlen_i                = 8'd0;
    awuser_i               = '0;
    awid_i                 = '0;
    awlock_i               = 1'b0;
    awvalid_i              = 1'b0;
    wdata_i                = '0;
    wstrb_i                = '0;
    wuser_i                = '0;
    wlast_i                = 1'b1;
    wvalid_i               = 1'b0;
    bready_i               = 1'b1;
    disable_id_filtering_i = 1'b0;
    priv_ids_i[0]          = 8'h11;
    priv_ids_i[1]          = 8'h22;
    priv_ids_i[2]          = 8'h33;
    priv_ids_i[3]          = 8'h44;
    shadow[0] = CSR_ID_VALUE;
    for (int i = 1; i < NUM_CSRS; i++) begin
      shadow[i] = '0;
    end

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    reset_and_id_test();
    lane_steering_test();
    error_response_test();
    id_filter_test();
    echo_backpressure_test();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* axi_csr_top.sv */
// Top level connecting the AXI front end, CSR bridge and register block
module axi_csr_top
  import axi_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  axi_addr_t araddr_i,
  input  logic [1:0] arburst_i,
  input  logic [2:0] arsize_i,
  input  logic [7:0] arlen_i,
  input  axi_user_t aruser_i,
  input  axi_id_t   arid_i,
  input  logic      arlock_i,
  input  logic      arvalid_i,
  output logic      arready_o,

  output axi_data_t rdata_o,
  output axi_resp_t rresp_o,
  output axi_id_t   rid_o,
  output axi_user_t ruser_o,
  output logic      rlast_o,
  output logic      rvalid_o,
  input  logic      rready_i,

  input  axi_addr_t awaddr_i,
  input  logic [1:0] awburst_i,
  input  logic [2:0] awsize_i,
  input  logic [7:0] awlen_i,
  input  axi_user_t awuser_i,
  input  axi_id_t   awid_i,
  input  logic      awlock_i,
  input  logic      awvalid_i,
  output logic      awready_o,

  input  axi_data_t wdata_i,
  input  axi_strb_t wstrb_i,
  input  axi_user_t wuser_i,
  input  logic      wlast_i,
  input  logic      wvalid_i,
  output logic      wready_o,

  output axi_resp_t bresp_o,
  output axi_id_t   bid_o,
  output axi_user_t buser_o,
  output logic      bvalid_o,
  input  logic      bready_i,

  input  logic      disable_id_filtering_i,
  input  axi_id_t   priv_ids_i [NUM_PRIV_IDS]
);

  logic      req_dv;
  comp_req_t req;
  logic      hld;
  comp_rsp_t rsp;
  logic      csr_req;
  csr_req_t  csr_req_data;
  csr_rsp_t  csr_rsp;

  // AXI channel ports connect by name
  axi_sub_frontend u_frontend (
    .*,
    .req_dv_o (req_dv),
    .req_o    (req),
    .hld_i    (hld),
    .rsp_i    (rsp)
  );

  csr_cpuif_bridge u_bridge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_dv_i       (req_dv),
    .req_i          (req),
    .hld_o          (hld),
    .rsp_o          (rsp),
    .csr_req_o      (csr_req),
    .csr_req_o_data (csr_req_data),
    .csr_rsp_i      (csr_rsp)
  );

  periph_csr_block u_csr_block (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_req_i      (csr_req),
    .csr_req_data_i (csr_req_data),
    .csr_rsp_o      (csr_rsp)
  );

endmodule

/* periph_csr_block.sv */
// Register block with an identification register and fifteen scratch registers
module periph_csr_block
  import axi_csr_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     csr_req_i,
  input  csr_req_t csr_req_data_i,
  output csr_rsp_t csr_rsp_o
);

  csr_data_t  scratch_q [1:NUM_CSRS-1];
  logic [3:0] index;
  logic       mapped;
  logic       rd_err, wr_err;
  csr_data_t  rd_val;
  logic       rd_ack_q, wr_ack_q;
  logic       rd_err_q, wr_err_q;
  csr_data_t  rd_data_q;

  // Anything at or above 0x040 is unmapped
  assign index  = csr_req_data_i.addr[5:2];
  assign mapped = (csr_req_data_i.addr[CSR_ADDR_W-1:6] == '0);

  // Register 0 is read-only
  assign wr_err = csr_req_data_i.is_wr & (~mapped | (index == 4'd0));
  assign rd_err = ~csr_req_data_i.is_wr & ~mapped;

  always_comb begin
    rd_val = CSR_ID_VALUE;
    for (int i = 1; i < NUM_CSRS; i++) begin
      if (index == i) rd_val = scratch_q[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      wr_err_q <= 1'b0;
      for (int i = 1; i < NUM_CSRS; i++) begin
        scratch_q[i] <= '0;
      end
    end else begin
      rd_ack_q <= csr_req_i & ~csr_req_data_i.is_wr;
      wr_ack_q <= csr_req_i & csr_req_data_i.is_wr;
      rd_err_q <= csr_req_i & rd_err;
      wr_err_q <= csr_req_i & wr_err;
      if (csr_req_i && csr_req_data_i.is_wr && !wr_err) begin
        for (int i = 1; i < NUM_CSRS; i++) begin
          if (index == i) begin
            scratch_q[i] <= (scratch_q[i] & ~csr_req_data_i.biten) |
                            (csr_req_data_i.wdata & csr_req_data_i.biten);
          end
        end
      end
    end
  end

  // Zero data on errors and on writes
  always_ff @(posedge clk_i) begin
    if (csr_req_i) begin
      rd_data_q <= (csr_req_data_i.is_wr || rd_err) ? '0 : rd_val;
    end
  end

  assign csr_rsp_o.rd_ack  = rd_ack_q;
  assign csr_rsp_o.wr_ack  = wr_ack_q;
  assign csr_rsp_o.rd_err  = rd_err_q;
  assign csr_rsp_o.wr_err  = wr_err_q;
  assign csr_rsp_o.rd_data = rd_data_q;

endmodule

/* csr_cpuif_bridge.sv */
// Bridge from the component request to a 32-bit CSR access with lane steering
module csr_cpuif_bridge
  import axi_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      req_dv_i,
  input  comp_req_t req_i,
  output logic      hld_o,
  output comp_rsp_t rsp_o,

  output logic      csr_req_o,
  output csr_req_t  csr_req_o_data,
  input  csr_rsp_t  csr_rsp_i
);

  logic       busy_q;
  logic       req_q;
  logic       issue;
  logic       ack;
  logic [5:0] lane_shift;
  axi_data_t  biten_wide;
  axi_data_t  wdata_sh;
  axi_data_t  biten_sh;

  assign ack   = csr_rsp_i.rd_ack | csr_rsp_i.wr_ack;
  assign issue = req_dv_i & ~busy_q;

  // One access outstanding at a time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
    end else begin
      req_q <= issue;
      if (issue) begin
        busy_q <= 1'b1;
      end else if (ack) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign csr_req_o = req_q;
  assign hld_o     = req_dv_i & ~ack;

  // Address bit 2 picks the 32-bit lane
  assign lane_shift = {req_i.addr[2], 5'd0};

  always_comb begin
    for (int i = 0; i < AXI_DATA_W / 8; i++) begin
      biten_wide[i*8 +: 8] = {8{req_i.wstrb[i]}};
    end
  end

  assign wdata_sh = req_i.wdata >> lane_shift;
  assign biten_sh = biten_wide >> lane_shift;

  assign csr_req_o_data.is_wr = req_i.write;
  assign csr_req_o_data.addr  = req_i.addr[CSR_ADDR_W-1:0];
  assign csr_req_o_data.wdata = wdata_sh[CSR_DATA_W-1:0];
  assign csr_req_o_data.biten = biten_sh[CSR_DATA_W-1:0];

  assign rsp_o.rdata = axi_data_t'(csr_rsp_i.rd_data) << lane_shift;
  assign rsp_o.err   = (csr_rsp_i.rd_ack & csr_rsp_i.rd_err) |
                       (csr_rsp_i.wr_ack & csr_rsp_i.wr_err);

endmodule

/* axi_sub_frontend.sv */
// AXI subordinate front end that filters IDs and turns single-beat transfers into requests
module axi_sub_frontend
  import axi_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  axi_addr_t araddr_i,
  input  logic [1:0] arburst_i,
  input  logic [2:0] arsize_i,
  input  logic [7:0] arlen_i,
  input  axi_user_t aruser_i,
  input  axi_id_t   arid_i,
  input  logic      arlock_i,
  input  logic      arvalid_i,
  output logic      arready_o,

  output axi_data_t rdata_o,
  output axi_resp_t rresp_o,
  output axi_id_t   rid_o,
  output axi_user_t ruser_o,
  output logic      rlast_o,
  output logic      rvalid_o,
  input  logic      rready_i,

  input  axi_addr_t awaddr_i,
  input  logic [1:0] awburst_i,
  input  logic [2:0] awsize_i,
  input  logic [7:0] awlen_i,
  input  axi_user_t awuser_i,
  input  axi_id_t   awid_i,
  input  logic      awlock_i,
  input  logic      awvalid_i,
  output logic      awready_o,

  input  axi_data_t wdata_i,
  input  axi_strb_t wstrb_i,
  input  axi_user_t wuser_i,
  input  logic      wlast_i,
  input  logic      wvalid_i,
  output logic      wready_o,

  output axi_resp_t bresp_o,
  output axi_id_t   bid_o,
  output axi_user_t buser_o,
  output logic      bvalid_o,
  input  logic      bready_i,

  input  logic      disable_id_filtering_i,
  input  axi_id_t   priv_ids_i [NUM_PRIV_IDS],

  output logic      req_dv_o,
  output comp_req_t req_o,
  input  logic      hld_i,
  input  comp_rsp_t rsp_i
);

  fe_state_e state_q, state_d;
  logic      ar_hs, aw_hs, w_hs;
  logic      ar_legal, aw_legal;
  logic      ar_ok, aw_ok;
  logic      legal_q, len_zero_q, is_write_q, err_q;
  logic      skip, done;
  axi_id_t   id_q;
  axi_user_t user_q;
  axi_addr_t addr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;
  axi_data_t rdata_q;

  // Privileged ID match
  always_comb begin
    ar_legal = disable_id_filtering_i;
    aw_legal = disable_id_filtering_i;
    for (int i = 0; i < NUM_PRIV_IDS; i++) begin
      if (arid_i == priv_ids_i[i]) ar_legal = 1'b1;
      if (awid_i == priv_ids_i[i]) aw_legal = 1'b1;
    end
  end

  assign ar_ok = ar_legal && (arlen_i == 8'd0);
  assign aw_ok = aw_legal && (awlen_i == 8'd0);

  // Reads take priority when idle
  assign arready_o = (state_q == IDLE);
  assign awready_o = ((state_q == IDLE) && !arvalid_i) || (state_q == WAIT_AW);
  assign wready_o  = ((state_q == IDLE) && !arvalid_i) || (state_q == WAIT_W);

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (ar_hs) begin
          state_d = ar_ok ? ISSUE : RESP_R;
        end else if (aw_hs && w_hs) begin
          state_d = aw_ok ? ISSUE : RESP_B;
        end else if (aw_hs) begin
          state_d = WAIT_W;
        end else if (w_hs) begin
          state_d = WAIT_AW;
        end
      end
      WAIT_W:  if (w_hs) state_d = (legal_q && len_zero_q) ? ISSUE : RESP_B;
      WAIT_AW: if (aw_hs) state_d = aw_ok ? ISSUE : RESP_B;
      ISSUE:   if (!hld_i) state_d = is_write_q ? RESP_B : RESP_R;
      RESP_R:  if (rready_i) state_d = IDLE;
      RESP_B:  if (bready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Rejected transfers go straight to a response
  assign skip = (state_q inside {IDLE, WAIT_W, WAIT_AW}) &&
                (state_d inside {RESP_R, RESP_B});
  assign done = (state_q == ISSUE) && !hld_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      legal_q    <= 1'b0;
      len_zero_q <= 1'b0;
      is_write_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        legal_q    <= ar_legal;
        len_zero_q <= (arlen_i == 8'd0);
        is_write_q <= 1'b0;
      end else if (aw_hs || w_hs) begin
        is_write_q <= 1'b1;
      end
      if (aw_hs) begin
        legal_q    <= aw_legal;
        len_zero_q <= (awlen_i == 8'd0);
      end
      if (skip) begin
        err_q <= 1'b1;
      end else if (done) begin
        err_q <= rsp_i.err;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q   <= arid_i;
      user_q <= aruser_i;
      addr_q <= araddr_i;
    end else if (aw_hs) begin
      id_q   <= awid_i;
      user_q <= awuser_i;
      addr_q <= awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (skip) begin
      rdata_q <= '0;
    end else if (done) begin
      rdata_q <= rsp_i.rdata;
    end
  end

  assign req_dv_o    = (state_q == ISSUE);
  assign req_o.write = is_write_q;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = wdata_q;
  assign req_o.wstrb = wstrb_q;

  assign rvalid_o = (state_q == RESP_R);
  assign rdata_o  = rdata_q;
  assign rresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign rid_o    = id_q;
  assign ruser_o  = user_q;
  assign rlast_o  = rvalid_o;

  assign bvalid_o = (state_q == RESP_B);
  assign bresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;
  assign bid_o    = id_q;
  assign buser_o  = user_q;

endmodule

/* axi_csr_pkg.sv */
// AXI to CSR bridge package with widths, register map, response codes and shared types
package axi_csr_pkg;

  localparam int unsigned AXI_DATA_W   = 64;
  localparam int unsigned AXI_ADDR_W   = 32;
  localparam int unsigned AXI_ID_W     = 8;
  localparam int unsigned AXI_USER_W   = 32;
  localparam int unsigned CSR_DATA_W   = 32;
  localparam int unsigned CSR_ADDR_W   = 12;
  localparam int unsigned NUM_PRIV_IDS = 4;
  localparam int unsigned NUM_CSRS     = 16;

  // Identification word returned by register 0
  localparam logic [CSR_DATA_W-1:0] CSR_ID_VALUE = 32'h1C3A_0001;

  typedef logic [AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [AXI_ID_W-1:0]     axi_id_t;
  typedef logic [AXI_USER_W-1:0]   axi_user_t;
  typedef logic [CSR_DATA_W-1:0]   csr_data_t;
  typedef logic [CSR_ADDR_W-1:0]   csr_addr_t;
  typedef logic [1:0]              axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // Front end to bridge
  typedef struct packed {
    logic      write;
    axi_addr_t addr;
    axi_data_t wdata;
    axi_strb_t wstrb;
  } comp_req_t;

  typedef struct packed {
    axi_data_t rdata;
    logic      err;
  } comp_rsp_t;

  // Bridge to register block
  typedef struct packed {
    logic      is_wr;
    csr_addr_t addr;
    csr_data_t wdata;
    csr_data_t biten;
  } csr_req_t;

  typedef struct packed {
    logic      rd_ack;
    logic      wr_ack;
    logic      rd_err;
    logic      wr_err;
    csr_data_t rd_data;
  } csr_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_W,
    WAIT_AW,
    ISSUE,
    RESP_R,
    RESP_B
  } fe_state_e;

endpackage
